// ==== Makefile ====
# Verilator build and run of the converter testbench

sim:
	verilator --binary --assert --timescale 1ns/1ps -f fsrc_top.f --top-module tb_fsrc -o sim_fsrc
	./obj_dir/sim_fsrc

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== fsrc_axil_regs.sv ====
// ----------------------------------------------------------
// AXI4-Lite control registers of the converter. Holds enable,
// increment and slot seeds, and pulses start, stop and load.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fsrc_axil_regs (
  input  wire         clk,
  input  wire         reset,
  input  wire  [31:0] awaddr,
  input  wire         awvalid,
  output logic        awready,
  input  wire  [31:0] wdata,
  input  wire  [3:0]  wstrb,
  input  wire         wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  wire         bready,
  input  wire  [31:0] araddr,
  input  wire         arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  wire         rready,
  fsrc_cfg_if.regs    cfg
);

  logic        aw_full;
  logic        w_full;
  logic [31:0] aw_addr_q;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0]  wr_strb;
  logic        do_write;
  logic [31:0] rd_word;

  function automatic logic [31:0] apply_strb(input logic [31:0] old_v, input logic [31:0] new_v,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_v[8*b +: 8];
    end
    return res;
  endfunction

  assign awready  = !aw_full && !bvalid;
  assign wready   = !w_full && !bvalid;
  assign wr_addr  = aw_full ? aw_addr_q : awaddr;   // Latched or live half
  assign wr_data  = w_full ? w_data_q : wdata;
  assign wr_strb  = w_full ? w_strb_q : wstrb;
  assign do_write = (aw_full || awvalid) && (w_full || wvalid) && !bvalid;
  assign bresp    = 2'b00;                          // Always OKAY
  assign rresp    = 2'b00;
  assign arready  = !rvalid;

  always_ff @(posedge clk) begin
    if (reset) begin
      aw_full       <= 1'b0;
      w_full        <= 1'b0;
      bvalid        <= 1'b0;
      cfg.enable    <= 1'b0;
      cfg.start     <= 1'b0;
      cfg.stop      <= 1'b0;
      cfg.seed_load <= 1'b0;
      cfg.add_val   <= '0;
      cfg.seed_val  <= '0;
    end else begin
      cfg.start     <= 1'b0;
      cfg.stop      <= 1'b0;
      cfg.seed_load <= 1'b0;
      if (bvalid && bready) bvalid <= 1'b0;
      if (do_write) begin
        aw_full <= 1'b0;
        w_full  <= 1'b0;
        bvalid  <= 1'b1;
        case (wr_addr)
          fsrc_pkg::reg_ctrl: begin
            if (wr_strb[0]) begin
              cfg.enable <= wr_data[0];
              cfg.start  <= wr_data[1];
              cfg.stop   <= wr_data[2];
            end
          end
          fsrc_pkg::reg_add:  cfg.add_val <= apply_strb(cfg.add_val, wr_data, wr_strb);
          fsrc_pkg::reg_load: cfg.seed_load <= 1'b1;
          default: begin
            if (wr_addr[31:4] == fsrc_pkg::reg_seed_base[31:4] && wr_addr[1:0] == 2'b00) begin
              cfg.seed_val[wr_addr[3:2]] <=
                apply_strb(cfg.seed_val[wr_addr[3:2]], wr_data, wr_strb);
            end
          end
        endcase
      end else begin
        if (awvalid && awready) aw_full <= 1'b1;
        if (wvalid && wready) w_full <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awvalid && awready) aw_addr_q <= awaddr;
    if (wvalid && wready) begin
      w_data_q <= wdata;
      w_strb_q <= wstrb;
    end
  end

  always_comb begin
    rd_word = '0;                                   // Unmapped reads as zero
    case (araddr)
      fsrc_pkg::reg_ctrl:   rd_word = {31'b0, cfg.enable};
      fsrc_pkg::reg_status: rd_word = {31'b0, cfg.running};
      fsrc_pkg::reg_add:    rd_word = cfg.add_val;
      default: begin
        if (araddr[31:4] == fsrc_pkg::reg_seed_base[31:4] && araddr[1:0] == 2'b00) begin
          rd_word = cfg.seed_val[araddr[3:2]];
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) rdata <= rd_word;
  end

endmodule

`default_nettype wire

// ==== fsrc_cfg_if.sv ====
// ----------------------------------------------------------
// Configuration bundle between the register block and the
// converter core. The core returns the running flag.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

interface fsrc_cfg_if;

  logic                                              enable;
  logic                                              start;      // One-cycle pulse
  logic                                              stop;       // One-cycle pulse
  logic [fsrc_pkg::accum_w-1:0]                      add_val;
  logic                                              seed_load;  // One-cycle pulse
  logic [fsrc_pkg::slots-1:0][fsrc_pkg::accum_w-1:0] seed_val;
  logic                                              running;

  modport regs (output enable, start, stop, add_val, seed_load, seed_val, input running);
  modport core (input enable, start, stop, add_val, seed_load, seed_val, output running);

endinterface

`default_nettype wire

// ==== fsrc_make_holes.sv ====
// ----------------------------------------------------------
// Repacks input samples into output beats. Valid slots take
// the oldest stored samples of each channel, holes get 0x8000.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fsrc_make_holes (
  input  wire                            clk,
  input  wire                            reset,
  input  wire fsrc_pkg::fsrc_beat_u      in_data,
  input  wire                            in_valid,
  output logic                           in_ready,
  input  wire fsrc_pkg::fsrc_slot_mask_t mask,
  input  wire                            mask_valid,
  output logic                           mask_take,
  output fsrc_pkg::fsrc_beat_u           out_data,
  output logic                           out_valid,
  input  wire                            out_ready
);

  logic [fsrc_pkg::num_ch-1:0][fsrc_pkg::slots-1:0][fsrc_pkg::sample_w-1:0]   left_q;
  logic [fsrc_pkg::num_ch-1:0][fsrc_pkg::slots-1:0][fsrc_pkg::sample_w-1:0]   left_next;
  logic [fsrc_pkg::num_ch-1:0][2*fsrc_pkg::slots-1:0][fsrc_pkg::sample_w-1:0] comb_s;
  logic [fsrc_pkg::cnt_w-1:0] cnt_q;                // Leftover samples per channel
  logic [fsrc_pkg::cnt_w-1:0] need;
  logic [fsrc_pkg::cnt_w-1:0] used;
  logic [fsrc_pkg::cnt_w-1:0] rank;
  logic                       fire;
  logic                       accept;
  fsrc_pkg::fsrc_beat_u       beat_s;

  always_comb begin
    need = '0;
    for (int s = 0; s < fsrc_pkg::slots; s++) need = need + fsrc_pkg::cnt_w'(mask[s]);
    fire = mask_valid && !(out_valid && !out_ready) &&
           (cnt_q + (in_valid ? fsrc_pkg::cnt_w'(fsrc_pkg::slots) : '0) >= need);
    used      = fire ? need : '0;
    in_ready  = (used >= cnt_q);                    // Leftover plus a new beat must fit
    accept    = in_valid && in_ready;
    mask_take = fire;

    // Stored samples first, the incoming beat right behind them
    comb_s = '0;
    for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
      for (int j = 0; j < fsrc_pkg::slots; j++) comb_s[c][j] = left_q[c][j];
      for (int j = 0; j < fsrc_pkg::slots; j++) comb_s[c][cnt_q + j] = in_data.smp[c][j];
    end

    rank = '0;
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
        beat_s.smp[c][s] = mask[s] ? comb_s[c][rank] : fsrc_pkg::invalid_sample;
      end
      rank = rank + fsrc_pkg::cnt_w'(mask[s]);
    end

    for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
      for (int j = 0; j < fsrc_pkg::slots; j++) left_next[c][j] = comb_s[c][used + j];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q     <= '0;
      out_valid <= 1'b0;
    end else begin
      cnt_q <= cnt_q + (accept ? fsrc_pkg::cnt_w'(fsrc_pkg::slots) : '0) - used;
      if (fire) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    left_q <= left_next;
    if (fire) out_data <= beat_s;
  end

endmodule

`default_nettype wire

// ==== fsrc_pkg.sv ====
// ----------------------------------------------------------
// Shared sizes, register map and types of the TX fractional
// sample-rate converter. Referenced by scoped name only.
// ----------------------------------------------------------

`default_nettype none

package fsrc_pkg;

  localparam int num_ch   = 4;
  localparam int sample_w = 16;
  localparam int slots    = 4;                          // Samples per channel per beat
  localparam int data_w   = num_ch * slots * sample_w;
  localparam int accum_w  = 32;
  localparam int cnt_w    = $clog2(2 * slots + 1);      // Sample store fill level

  localparam logic [sample_w-1:0] invalid_sample = {1'b1, {(sample_w-1){1'b0}}};

  localparam logic [31:0] reg_ctrl      = 32'h00;       // enable, start, stop
  localparam logic [31:0] reg_status    = 32'h04;
  localparam logic [31:0] reg_add       = 32'h08;
  localparam logic [31:0] reg_load     = 32'h0C;
  localparam logic [31:0] reg_seed_base = 32'h10;       // Slots 0..3 at 0x10..0x1C

  typedef logic [slots-1:0] fsrc_slot_mask_t;           // 1 marks a valid sample

  // One stream beat, seen as a flat bus or as channel/slot samples
  typedef union packed {
    logic [data_w-1:0]                          flat;
    logic [num_ch-1:0][slots-1:0][sample_w-1:0] smp;
  } fsrc_beat_u;

endpackage

`default_nettype wire

// ==== fsrc_sample_en_gen.sv ====
// ----------------------------------------------------------
// Per-slot phase accumulators. The carry of each slot's next
// sum marks whether that slot holds a real sample.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fsrc_sample_en_gen (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       take,
  fsrc_cfg_if.core                  cfg,
  output fsrc_pkg::fsrc_slot_mask_t mask,
  output logic                      mask_valid
);

  logic [fsrc_pkg::slots-1:0][fsrc_pkg::accum_w-1:0] accum_q;
  logic [fsrc_pkg::slots-1:0][fsrc_pkg::accum_w:0]   sum_s;   // Carry in the top bit

  always_comb begin
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      sum_s[s] = {1'b0, accum_q[s]} + {1'b0, cfg.add_val};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      accum_q    <= '0;
      mask       <= '0;
      mask_valid <= 1'b0;
    end else begin
      if (cfg.seed_load) begin
        accum_q <= cfg.seed_val;
      end else if (take) begin
        for (int s = 0; s < fsrc_pkg::slots; s++) begin
          accum_q[s] <= sum_s[s][fsrc_pkg::accum_w-1:0];
        end
      end
      for (int s = 0; s < fsrc_pkg::slots; s++) begin
        mask[s] <= sum_s[s][fsrc_pkg::accum_w];
      end
      mask_valid <= !(cfg.seed_load || take);       // Mask settles from the new sums
    end
  end

endmodule

`default_nettype wire

// ==== fsrc_skid_fifo.sv ====
// ----------------------------------------------------------
// Two-entry valid/ready buffer. Both in_ready and out_valid
// come from flops, so no ready path crosses the buffer.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fsrc_skid_fifo #(
  parameter int width = 256
) (
  input  wire              clk,
  input  wire              reset,
  input  wire  [width-1:0] in_data,
  input  wire              in_valid,
  output logic             in_ready,
  output logic [width-1:0] out_data,
  output logic             out_valid,
  input  wire              out_ready
);

  logic [width-1:0] skid_q;
  logic             skid_v;
  logic             push;
  logic             pop;
  logic [1:0]       cnt_next;

  assign push     = in_valid && in_ready;
  assign pop      = out_valid && out_ready;
  assign cnt_next = {1'b0, out_valid} + {1'b0, skid_v} + {1'b0, push} - {1'b0, pop};

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      skid_v    <= 1'b0;
      in_ready  <= 1'b0;
    end else begin
      out_valid <= (cnt_next != 2'd0);
      skid_v    <= (cnt_next == 2'd2);
      in_ready  <= (cnt_next != 2'd2);                // Full blocks the next push
    end
  end

  always_ff @(posedge clk) begin
    if (pop && skid_v) begin
      out_data <= skid_q;
    end else if (push && (!out_valid || pop)) begin
      out_data <= in_data;
    end
    if (push && out_valid && !pop) skid_q <= in_data;
  end

endmodule

`default_nettype wire

// ==== fsrc_top.f ====
fsrc_pkg.sv
fsrc_cfg_if.sv
fsrc_axil_regs.sv
fsrc_skid_fifo.sv
fsrc_sample_en_gen.sv
fsrc_make_holes.sv
tx_fsrc.sv
fsrc_top.sv
tb_fsrc.sv

// ==== fsrc_top.sv ====
// ----------------------------------------------------------
// Top level of the TX fractional sample-rate converter.
// AXI4-Lite control and the sample streams as plain ports.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fsrc_top (
  input  wire                          clk,
  input  wire                          reset,
  input  wire  [31:0]                  awaddr,
  input  wire                          awvalid,
  output wire                          awready,
  input  wire  [31:0]                  wdata,
  input  wire  [3:0]                   wstrb,
  input  wire                          wvalid,
  output wire                          wready,
  output wire  [1:0]                   bresp,
  output wire                          bvalid,
  input  wire                          bready,
  input  wire  [31:0]                  araddr,
  input  wire                          arvalid,
  output wire                          arready,
  output wire  [31:0]                  rdata,
  output wire  [1:0]                   rresp,
  output wire                          rvalid,
  input  wire                          rready,
  input  wire  [fsrc_pkg::data_w-1:0]  in_data,
  input  wire                          in_valid,
  output wire                          in_ready,
  output wire  [fsrc_pkg::data_w-1:0]  out_data,
  output wire                          out_valid,
  input  wire                          out_ready
);

  fsrc_cfg_if cfg0 ();

  fsrc_axil_regs regs0 (
    .clk     (clk),
    .reset   (reset),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cfg     (cfg0)
  );

  tx_fsrc core0 (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .cfg       (cfg0)
  );

endmodule

`default_nettype wire

// ==== tb_fsrc.sv ====
// ----------------------------------------------------------
// Self-checking testbench of the TX fractional sample-rate
// converter. Covers register access, bypass, idle hole fill,
// the conversion pattern and back-pressure on both streams.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_fsrc;

  localparam int mode_none    = 0;
  localparam int mode_bypass  = 1;
  localparam int mode_idle    = 2;
  localparam int mode_convert = 3;
  localparam logic [fsrc_pkg::data_w-1:0] all_holes =
    {(fsrc_pkg::num_ch * fsrc_pkg::slots){16'h8000}};

  logic                        clk;
  logic                        reset;
  logic [31:0]                 awaddr;
  logic                        awvalid;
  wire                         awready;
  logic [31:0]                 wdata;
  logic [3:0]                  wstrb;
  logic                        wvalid;
  wire                         wready;
  wire  [1:0]                  bresp;
  wire                         bvalid;
  logic                        bready;
  logic [31:0]                 araddr;
  logic                        arvalid;
  wire                         arready;
  wire  [31:0]                 rdata;
  wire  [1:0]                  rresp;
  wire                         rvalid;
  logic                        rready;
  logic [fsrc_pkg::data_w-1:0] in_data;
  logic                        in_valid;
  wire                         in_ready;
  wire  [fsrc_pkg::data_w-1:0] out_data;
  wire                         out_valid;
  logic                        out_ready;

  logic [31:0]                 rng = 32'd50738;
  int                          mode = mode_none;
  int                          send_left = 0;
  int                          idle_beats = 0;
  int                          conv_beats = 0;
  logic                        rand_gaps = 1'b0;
  logic                        skip_lead = 1'b0;
  logic                        in_took = 1'b0;
  logic                        hold_prev = 1'b0;
  logic [fsrc_pkg::data_w-1:0] held_data;
  logic [fsrc_pkg::data_w-1:0] beat_q [$];                      // Bypass model
  logic [15:0]                 ch_q [fsrc_pkg::num_ch][$];      // Sent samples per channel
  logic [31:0]                 acc_m [fsrc_pkg::slots];         // Slot accumulator model
  logic [31:0]                 add_m;

  fsrc_top dut0 (
    .clk (clk), .reset (reset),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .in_data (in_data), .in_valid (in_valid), .in_ready (in_ready),
    .out_data (out_data), .out_valid (out_valid), .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // No input beat may be taken while enabled but not started
  assert property (@(posedge clk) disable iff (reset) !(mode == mode_idle && in_valid && in_ready))
    else abort_run("Fail in_ready 1 expected 0 during idle hole fill");

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int   n;
    logic aw_go;
    logic w_go;
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (awvalid || wvalid) begin
      aw_go = awvalid && awready;                 // Taken at the next rising edge
      w_go  = wvalid && wready;
      @(negedge clk);
      if (aw_go) awvalid = 1'b0;
      if (w_go) wvalid = 1'b0;
      n++;
      if (n > 50) abort_run("write address or data was never accepted");
    end
    n = 0;
    while (!bvalid) begin
      @(negedge clk);
      n++;
      if (n > 50) abort_run("write response never arrived");
    end
    assert (bresp == 2'b00) else abort_run($sformatf("Fail bresp %h expected 0", bresp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic check_reg(input logic [31:0] addr, input logic [31:0] exp_v);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready) begin
      @(negedge clk);
      n++;
      if (n > 50) abort_run("read address was never accepted");
    end
    @(negedge clk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      @(negedge clk);
      n++;
      if (n > 50) abort_run("read data never arrived");
    end
    assert (rdata == exp_v)
      else abort_run($sformatf("Fail rdata %h expected %h at %h", rdata, exp_v, addr));
    assert (rresp == 2'b00) else abort_run($sformatf("Fail rresp %h expected 0", rresp));
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic predict_beat(output fsrc_pkg::fsrc_beat_u exp_b);
    logic [32:0] sum;
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      sum = {1'b0, acc_m[s]} + {1'b0, add_m};     // Carry marks a real sample
      acc_m[s] = sum[31:0];
      for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
        if (!sum[32]) begin
          exp_b.smp[c][s] = 16'h8000;
        end else if (ch_q[c].size() == 0) begin
          abort_run("output beat needs a sample that was never sent");
        end else begin
          exp_b.smp[c][s] = ch_q[c].pop_front();
        end
      end
    end
  endtask

  task automatic check_out_beat(input logic [fsrc_pkg::data_w-1:0] got);
    fsrc_pkg::fsrc_beat_u exp_b;
    case (mode)
      mode_bypass: begin
        if (beat_q.size() == 0) abort_run("bypass output beat without a matching input beat");
        exp_b.flat = beat_q.pop_front();
        assert (got == exp_b.flat)
          else abort_run($sformatf("Fail out_data %h expected %h", got, exp_b.flat));
      end
      mode_idle: begin
        assert (got == all_holes)
          else abort_run($sformatf("Fail out_data %h expected %h", got, all_holes));
        idle_beats++;
      end
      mode_convert: begin
        if (!(skip_lead && got == all_holes)) begin  // Idle beats still in flight
          skip_lead = 1'b0;
          predict_beat(exp_b);
          assert (got == exp_b.flat)
            else abort_run($sformatf("Fail out_data %h expected %h", got, exp_b.flat));
          conv_beats++;
        end
      end
      default: abort_run("output beat appeared while no traffic was expected");
    endcase
  endtask

  task automatic drive_input();
    fsrc_pkg::fsrc_beat_u b;
    if (!in_valid || in_took) begin
      in_valid = 1'b0;
      if (send_left > 0 && (!rand_gaps || (next_rand() & 32'h3) != 0)) begin
        for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
          for (int s = 0; s < fsrc_pkg::slots; s++) b.smp[c][s] = 16'(next_rand());
        end
        in_data  = b.flat;
        in_valid = 1'b1;
        send_left--;
      end
    end
    in_took = in_valid && in_ready;
    if (in_took) begin
      b.flat = in_data;
      if (mode == mode_bypass) beat_q.push_back(in_data);
      if (mode == mode_convert) begin
        for (int c = 0; c < fsrc_pkg::num_ch; c++) begin
          for (int s = 0; s < fsrc_pkg::slots; s++) ch_q[c].push_back(b.smp[c][s]);
        end
      end
    end
  endtask

  task automatic drive_output();
    if (hold_prev) begin
      assert (out_valid) else abort_run("out_valid dropped before its beat was taken");
      assert (out_data == held_data)
        else abort_run($sformatf("Fail out_data %h expected %h while stalled",
                                 out_data, held_data));
    end
    out_ready = rand_gaps ? ((next_rand() & 32'h3) != 0) : 1'b1;
    if (out_valid && out_ready) check_out_beat(out_data);
    hold_prev = out_valid && !out_ready;
    held_data = out_data;
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      drive_input();
      drive_output();
    end
  end

  initial begin
    int n;
    reset     = 1'b1;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    in_data   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    repeat (16) @(negedge clk);
    assert (!out_valid && !in_ready && !bvalid && !rvalid)
      else abort_run($sformatf("Fail reset state out_valid %h in_ready %h bvalid %h rvalid %h",
                               out_valid, in_ready, bvalid, rvalid));
    reset = 1'b0;

    write_reg(fsrc_pkg::reg_add, 32'h1234_5678, 4'hF);
    check_reg(fsrc_pkg::reg_add, 32'h1234_5678);
    write_reg(fsrc_pkg::reg_add, 32'hFFFF_FFFF, 4'h3);     // Low two bytes only
    check_reg(fsrc_pkg::reg_add, 32'h1234_FFFF);
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      write_reg(fsrc_pkg::reg_seed_base + 32'(4 * s), 32'h5A5A_0000 | 32'(s), 4'hF);
    end
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      check_reg(fsrc_pkg::reg_seed_base + 32'(4 * s), 32'h5A5A_0000 | 32'(s));
    end
    check_reg(32'h40, 32'h0);
    check_reg(fsrc_pkg::reg_load, 32'h0);
    check_reg(fsrc_pkg::reg_ctrl, 32'h0);
    check_reg(fsrc_pkg::reg_status, 32'h0);

    mode = mode_bypass;
    rand_gaps = 1'b1;
    send_left = 24;
    n = 0;
    while (send_left > 0 || in_valid || beat_q.size() != 0) begin
      @(negedge clk);
      n++;
      if (n > 2000) abort_run("bypass beats did not come through in time");
    end
    rand_gaps = 1'b0;

    mode = mode_idle;
    write_reg(fsrc_pkg::reg_ctrl, 32'h1, 4'hF);
    check_reg(fsrc_pkg::reg_ctrl, 32'h1);
    send_left = 1;                                         // Held at the input, never taken
    n = 0;
    while (idle_beats < 8) begin
      @(negedge clk);
      n++;
      if (n > 500) abort_run("idle hole fill produced too few beats");
    end

    // One slot per quarter, so every beat has exactly one hole
    add_m = 32'hC000_0000;
    write_reg(fsrc_pkg::reg_add, add_m, 4'hF);
    for (int s = 0; s < fsrc_pkg::slots; s++) begin
      acc_m[s] = 32'h0123_4567 + 32'(s) * 32'h4444_4444;
      write_reg(fsrc_pkg::reg_seed_base + 32'(4 * s), acc_m[s], 4'hF);
    end
    write_reg(fsrc_pkg::reg_load, 32'h1, 4'hF);
    skip_lead = 1'b1;
    mode = mode_convert;
    send_left = send_left + 15;
    write_reg(fsrc_pkg::reg_ctrl, 32'h3, 4'hF);
    check_reg(fsrc_pkg::reg_status, 32'h1);
    n = 0;
    while (conv_beats < 12) begin
      @(negedge clk);
      n++;
      if (n > 1000) abort_run("conversion produced too few beats");
    end

    rand_gaps = 1'b1;
    send_left = send_left + 48;
    n = 0;
    while (send_left > 0 || in_valid || ch_q[0].size() >= 3) begin
      @(negedge clk);
      n++;
      if (n > 5000) abort_run("conversion under back-pressure did not drain in time");
    end
    rand_gaps = 1'b0;

    mode = mode_idle;
    idle_beats = 0;
    write_reg(fsrc_pkg::reg_ctrl, 32'h5, 4'hF);
    check_reg(fsrc_pkg::reg_status, 32'h0);
    n = 0;
    while (idle_beats < 4) begin
      @(negedge clk);
      n++;
      if (n > 500) abort_run("no hole beats after stop");
    end

    // 64 beats of 4 samples, 3 samples per output beat
    if (conv_beats != 85) begin
      abort_run($sformatf("Fail conv_beats %h expected %h", conv_beats, 85));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== tx_fsrc.sv ====
// ----------------------------------------------------------
// Converter core. Buffers the stream on both sides and either
// bypasses it or inserts holes after the run control.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tx_fsrc (
  input  wire                          clk,
  input  wire                          reset,
  input  wire  [fsrc_pkg::data_w-1:0]  in_data,
  input  wire                          in_valid,
  output logic                         in_ready,
  output logic [fsrc_pkg::data_w-1:0]  out_data,
  output logic                         out_valid,
  input  wire                          out_ready,
  fsrc_cfg_if.core                     cfg
);

  logic                        accept_ok;
  logic                        inf_in_valid;
  logic                        inf_in_ready;
  logic [fsrc_pkg::data_w-1:0] inf_data;
  logic                        inf_valid;
  logic                        inf_ready;
  fsrc_pkg::fsrc_beat_u        holes_in;
  logic                        holes_in_valid;
  logic                        holes_in_ready;
  fsrc_pkg::fsrc_beat_u        holes_out;
  logic                        holes_out_valid;
  logic                        holes_out_ready;
  fsrc_pkg::fsrc_slot_mask_t   gen_mask;
  fsrc_pkg::fsrc_slot_mask_t   holes_mask;
  logic                        gen_mask_valid;
  logic                        holes_mask_valid;
  logic                        mask_take;
  logic [fsrc_pkg::data_w-1:0] outf_data;
  logic                        outf_valid;
  logic                        outf_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.running <= 1'b0;
    end else if (!cfg.enable || cfg.stop) begin
      cfg.running <= 1'b0;
    end else if (cfg.start) begin
      cfg.running <= 1'b1;
    end
  end

  // Idle hole fill takes no input at all
  assign accept_ok    = !cfg.enable || cfg.running;
  assign inf_in_valid = in_valid && accept_ok;
  assign in_ready     = inf_in_ready && accept_ok;

  fsrc_skid_fifo #(
    .width (fsrc_pkg::data_w)
  ) in_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (inf_in_valid),
    .in_ready  (inf_in_ready),
    .out_data  (inf_data),
    .out_valid (inf_valid),
    .out_ready (inf_ready)
  );

  assign holes_in.flat    = inf_data;
  assign holes_in_valid   = inf_valid && cfg.enable && cfg.running;
  assign inf_ready        = cfg.enable ? (holes_in_ready && cfg.running) : outf_ready;
  assign holes_mask       = cfg.running ? gen_mask : '0;      // Stopped means all holes
  assign holes_mask_valid = cfg.running ? gen_mask_valid : 1'b1;
  assign holes_out_ready  = cfg.enable && outf_ready;

  fsrc_sample_en_gen gen0 (
    .clk        (clk),
    .reset      (reset),
    .take       (mask_take && cfg.running),
    .cfg        (cfg),
    .mask       (gen_mask),
    .mask_valid (gen_mask_valid)
  );

  fsrc_make_holes holes0 (
    .clk        (clk),
    .reset      (reset),
    .in_data    (holes_in),
    .in_valid   (holes_in_valid),
    .in_ready   (holes_in_ready),
    .mask       (holes_mask),
    .mask_valid (holes_mask_valid),
    .mask_take  (mask_take),
    .out_data   (holes_out),
    .out_valid  (holes_out_valid),
    .out_ready  (holes_out_ready)
  );

  assign outf_data  = cfg.enable ? holes_out.flat : inf_data;  // Bypass when disabled
  assign outf_valid = cfg.enable ? holes_out_valid : inf_valid;

  fsrc_skid_fifo #(
    .width (fsrc_pkg::data_w)
  ) out_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_data   (outf_data),
    .in_valid  (outf_valid),
    .in_ready  (outf_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire
